// ==== common/dsp_pkg.sv ====
/*
 * Sizes, word types and write structs shared by the DSP core blocks.
 * Buffer depths follow the address widths (acq 8192, dacmon 512, accbuf 2048).
 * The last slot of every buffer doubles as the lock position of its counter.
 */

package dsp_pkg;

	localparam int nproc = 4;
	localparam int nadc = 2;
	localparam int ndac = 4;

	localparam int adc_word_w = 64;      // four 16-bit samples.
	localparam int dac_word_w = 256;     // sixteen 16-bit samples.
	localparam int acc_val_w = 32;
	localparam int shot_cnt_w = 32;
	localparam int acq_addr_w = 13;
	localparam int dacmon_addr_w = 9;
	localparam int accbuf_addr_w = 11;

	typedef logic [adc_word_w-1:0] adc_word_t;
	typedef logic [dac_word_w-1:0] dac_word_t;
	typedef logic [acc_val_w-1:0] acc_val_t;
	typedef logic [shot_cnt_w-1:0] shot_cnt_t;
	typedef logic [acq_addr_w-1:0] acq_addr_t;
	typedef logic [dacmon_addr_w-1:0] dacmon_addr_t;
	typedef logic [accbuf_addr_w-1:0] accbuf_addr_t;

	// x lands in the upper word of the buffer entry.
	typedef struct packed {
		acc_val_t acc_x;
		acc_val_t acc_y;
	} acc_result_t;

	typedef struct packed {
		logic we;
		acq_addr_t addr;
		adc_word_t data;
	} acq_wr_t;

	typedef struct packed {
		logic we;
		dacmon_addr_t addr;
		dac_word_t data;
	} dacmon_wr_t;

	typedef struct packed {
		logic we;
		accbuf_addr_t addr;
		acc_result_t data;
	} accbuf_wr_t;

	typedef enum logic [2:0] {
		idle,
		start,
		proc_run,
		elem_busy,
		more_shot,
		done
	} seq_state_t;

endpackage

// ==== sequencer/shot_sequencer.sv ====
/*
 * Runs the processor cores max(nshot, 1) times from one stb_start pulse.
 * proc_done and no_busy are levels; all bits must be high to advance.
 * nshot is sampled while idle and at each shot start, so change it only
 * between runs. last_shot_done is a single-cycle pulse at the end of a run.
 */
`timescale 1ns/1ps

module shot_sequencer (
	input logic dspif,
	input logic rst_n,
	input logic stb_start,
	input dsp_pkg::shot_cnt_t nshot,
	input logic [dsp_pkg::nproc-1:0] proc_done,
	input logic [dsp_pkg::nproc-1:0] no_busy,
	output logic [dsp_pkg::nproc-1:0] proc_reset,
	output dsp_pkg::shot_cnt_t shot_cnt,
	output logic last_shot_done
);

	dsp_pkg::seq_state_t state;
	dsp_pkg::seq_state_t next_state;
	dsp_pkg::shot_cnt_t nshot_q;
	logic core_reset;
	logic last_shot;

	// shot_cnt already counts the shot that just finished.
	assign last_shot = (nshot_q == '0) || (shot_cnt == nshot_q);

	always_comb begin
		next_state = state;
		case (state)
			dsp_pkg::idle: begin
				if (stb_start) begin
					next_state = dsp_pkg::start;
				end
			end
			dsp_pkg::start: begin
				next_state = dsp_pkg::proc_run;
			end
			dsp_pkg::proc_run: begin
				if (&proc_done) begin
					next_state = dsp_pkg::elem_busy;
				end
			end
			dsp_pkg::elem_busy: begin
				if (&no_busy) begin
					next_state = dsp_pkg::more_shot;
				end
			end
			dsp_pkg::more_shot: begin
				next_state = last_shot ? dsp_pkg::done : dsp_pkg::start;
			end
			dsp_pkg::done: begin
				next_state = dsp_pkg::idle;
			end
			default: begin
				next_state = dsp_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			state <= dsp_pkg::idle;
			core_reset <= 1'b1;
			proc_reset <= '1;
			last_shot_done <= 1'b0;
			shot_cnt <= '0;
			nshot_q <= '0;
		end else begin
			state <= next_state;
			proc_reset <= {dsp_pkg::nproc{core_reset}}; // one cycle behind the flag.
			last_shot_done <= (next_state == dsp_pkg::done);
			case (next_state)
				dsp_pkg::idle: begin
					core_reset <= 1'b1;
					shot_cnt <= '0;
					nshot_q <= nshot;
				end
				dsp_pkg::start: begin
					core_reset <= 1'b0; // release cores for the next shot.
					nshot_q <= nshot;
				end
				dsp_pkg::proc_run: begin
					core_reset <= 1'b0;
				end
				dsp_pkg::elem_busy: begin
					core_reset <= 1'b1;
				end
				dsp_pkg::more_shot: begin
					core_reset <= 1'b1;
					shot_cnt <= shot_cnt + 1'b1;
				end
				dsp_pkg::done: begin
					core_reset <= 1'b1;
					shot_cnt <= '0;
				end
				default: begin
					core_reset <= 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== logic/acq_capture.sv ====
/*
 * Writes each ADC stream into its acquisition buffer after a rearm pulse.
 * Latency is four cycles; address 0 holds the word seen with the rearm pulse.
 * The counter stops at all ones and that slot is never written.
 * Nothing is written after reset until the first rearm.
 */
`timescale 1ns/1ps

module acq_capture (
	input logic dspif,
	input logic rst_n,
	input logic rearm_capture,
	input dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] adc,
	output dsp_pkg::acq_wr_t [dsp_pkg::nadc-1:0] acq_wr
);

	dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] adc_q;
	dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] data_q;
	dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] data_d;
	dsp_pkg::acq_addr_t [dsp_pkg::nadc-1:0] addr;
	dsp_pkg::acq_addr_t [dsp_pkg::nadc-1:0] addr_d;
	logic [dsp_pkg::nadc-1:0] we_d;
	logic rearm_q;

	always_ff @(posedge dspif) begin
		for (int i = 0; i < dsp_pkg::nadc; i++) begin
			adc_q[i] <= adc[i];
			data_q[i] <= adc_q[i];
			data_d[i] <= data_q[i];
			acq_wr[i].data <= data_d[i]; // fourth stage.
		end
		if (!rst_n) begin
			rearm_q <= 1'b0;
			for (int i = 0; i < dsp_pkg::nadc; i++) begin
				addr[i] <= '1; // locked until rearm.
				addr_d[i] <= '1;
				we_d[i] <= 1'b0;
				acq_wr[i].addr <= '1;
				acq_wr[i].we <= 1'b0;
			end
		end else begin
			rearm_q <= rearm_capture;
			for (int i = 0; i < dsp_pkg::nadc; i++) begin
				if (rearm_q) begin
					addr[i] <= '0;
				end else if (!(&addr[i])) begin
					addr[i] <= addr[i] + 1'b1;
				end
				addr_d[i] <= addr[i]; // line up with data stage 3.
				we_d[i] <= !(&addr[i]);
				acq_wr[i].addr <= addr_d[i];
				acq_wr[i].we <= we_d[i];
			end
		end
	end

endmodule

// ==== logic/dacmon_capture.sv ====
/*
 * Monitors the four DAC words into the DAC monitor buffers.
 * All channels share one address counter, cleared by rearm_capture.
 * Address k holds the word seen k+1 cycles after the rearm pulse.
 * The all-ones slot is the lock position and is never written.
 */
`timescale 1ns/1ps

module dacmon_capture (
	input logic dspif,
	input logic rst_n,
	input logic rearm_capture,
	input dsp_pkg::dac_word_t [dsp_pkg::ndac-1:0] dac_word,
	output dsp_pkg::dacmon_wr_t [dsp_pkg::ndac-1:0] dacmon_wr
);

	dsp_pkg::dac_word_t [dsp_pkg::ndac-1:0] dac_q;
	dsp_pkg::dacmon_addr_t addr;
	logic rearm_q;

	always_ff @(posedge dspif) begin
		for (int i = 0; i < dsp_pkg::ndac; i++) begin
			dac_q[i] <= dac_word[i];
			dacmon_wr[i].data <= dac_q[i];
		end
		if (!rst_n) begin
			rearm_q <= 1'b0;
			addr <= '1;
			for (int i = 0; i < dsp_pkg::ndac; i++) begin
				dacmon_wr[i].addr <= '1;
				dacmon_wr[i].we <= 1'b0;
			end
		end else begin
			rearm_q <= rearm_capture;
			if (rearm_q) begin
				addr <= '0;
			end else if (!(&addr)) begin
				addr <= addr + 1'b1;
			end
			for (int i = 0; i < dsp_pkg::ndac; i++) begin
				dacmon_wr[i].addr <= addr; // same address on every channel.
				dacmon_wr[i].we <= !(&addr);
			end
		end
	end

endmodule

// ==== logic/acc_pointer.sv ====
/*
 * Turns per-processor result strobes into accumulation-buffer writes.
 * Each write follows its strobe by one cycle and uses the current fill address.
 * reset_acc is a level and holds every address at zero while high.
 * A full buffer keeps overwriting its last slot.
 */
`timescale 1ns/1ps

module acc_pointer (
	input logic dspif,
	input logic rst_n,
	input logic reset_acc,
	input logic [dsp_pkg::nproc-1:0] acc_valid,
	input dsp_pkg::acc_result_t [dsp_pkg::nproc-1:0] acc_result,
	output dsp_pkg::accbuf_wr_t [dsp_pkg::nproc-1:0] accbuf_wr
);

	logic reset_acc_q;

	always_ff @(posedge dspif) begin
		for (int i = 0; i < dsp_pkg::nproc; i++) begin
			accbuf_wr[i].data <= acc_result[i];
		end
		if (!rst_n) begin
			reset_acc_q <= 1'b0;
			for (int i = 0; i < dsp_pkg::nproc; i++) begin
				accbuf_wr[i].we <= 1'b0;
				accbuf_wr[i].addr <= '0;
			end
		end else begin
			reset_acc_q <= reset_acc;
			for (int i = 0; i < dsp_pkg::nproc; i++) begin
				accbuf_wr[i].we <= acc_valid[i];
				// advance after the write that used this address.
				if (reset_acc_q) begin
					accbuf_wr[i].addr <= '0;
				end else if (accbuf_wr[i].we && !(&accbuf_wr[i].addr)) begin
					accbuf_wr[i].addr <= accbuf_wr[i].addr + 1'b1;
				end
			end
		end
	end

endmodule

// ==== logic/dsp_top.sv ====
/*
 * Top of the DSP core with the shot sequencer and the three buffer write generators.
 * Core flags and mixer results come from outside the block.
 * Buffers are assumed to accept a write every cycle.
 */
`timescale 1ns/1ps

module dsp_top (
	input logic dspif,
	input logic rst_n,
	input logic stb_start,
	input dsp_pkg::shot_cnt_t nshot,
	input logic [dsp_pkg::nproc-1:0] proc_done,
	input logic [dsp_pkg::nproc-1:0] no_busy,
	input logic rearm_capture,
	input dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] adc,
	input dsp_pkg::dac_word_t [dsp_pkg::ndac-1:0] dac_word,
	input logic reset_acc,
	input logic [dsp_pkg::nproc-1:0] acc_valid,
	input dsp_pkg::acc_result_t [dsp_pkg::nproc-1:0] acc_result,
	output logic [dsp_pkg::nproc-1:0] proc_reset,
	output dsp_pkg::shot_cnt_t shot_cnt,
	output logic last_shot_done,
	output dsp_pkg::acq_wr_t [dsp_pkg::nadc-1:0] acq_wr,
	output dsp_pkg::dacmon_wr_t [dsp_pkg::ndac-1:0] dacmon_wr,
	output dsp_pkg::accbuf_wr_t [dsp_pkg::nproc-1:0] accbuf_wr
);

	shot_sequencer sequencer (
		.dspif(dspif),
		.rst_n(rst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.proc_done(proc_done),
		.no_busy(no_busy),
		.proc_reset(proc_reset),
		.shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done)
	);

	// both capture blocks rearm from the same pulse.
	acq_capture acq (
		.dspif(dspif),
		.rst_n(rst_n),
		.rearm_capture(rearm_capture),
		.adc(adc),
		.acq_wr(acq_wr)
	);

	dacmon_capture dacmon (
		.dspif(dspif),
		.rst_n(rst_n),
		.rearm_capture(rearm_capture),
		.dac_word(dac_word),
		.dacmon_wr(dacmon_wr)
	);

	acc_pointer acc (
		.dspif(dspif),
		.rst_n(rst_n),
		.reset_acc(reset_acc),
		.acc_valid(acc_valid),
		.acc_result(acc_result),
		.accbuf_wr(accbuf_wr)
	);

endmodule

// ==== test/tb_clock.sv ====
/* Testbench clock and reset generator with a 10 ns period. rst_n is low for 10 cycles. */
`timescale 1ns/1ps

module tb_clock (
	output logic dspif,
	output logic rst_n
);

	initial begin
		dspif = 1'b0;
		forever #5 dspif = ~dspif;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge dspif);
		#1 rst_n = 1'b1; // released just after an edge.
	end

endmodule

// ==== test/dsp_checker.sv ====
/*
 * Watches the DUT ports and compares them with values built from the input history.
 * Samples at the rising edge, so outputs seen there belong to the cycle before.
 * Assumes no acc_valid strobe while reset_acc is high.
 */
`timescale 1ns/1ps

module dsp_checker (
	input logic dspif,
	input logic rst_n,
	input logic rearm_capture,
	input dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] adc,
	input dsp_pkg::dac_word_t [dsp_pkg::ndac-1:0] dac_word,
	input logic reset_acc,
	input logic [dsp_pkg::nproc-1:0] acc_valid,
	input dsp_pkg::acc_result_t [dsp_pkg::nproc-1:0] acc_result,
	input logic [dsp_pkg::nproc-1:0] proc_reset,
	input dsp_pkg::shot_cnt_t shot_cnt,
	input logic last_shot_done,
	input dsp_pkg::acq_wr_t [dsp_pkg::nadc-1:0] acq_wr,
	input dsp_pkg::dacmon_wr_t [dsp_pkg::ndac-1:0] dacmon_wr,
	input dsp_pkg::accbuf_wr_t [dsp_pkg::nproc-1:0] accbuf_wr,
	input int exp_shots,
	output int errors
);

	int mismatches = 0;
	int failures = 0;
	int checks = 0;
	int cycle;
	bit reset_applied = 1'b0;
	dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] adc_hist[$];
	dsp_pkg::dac_word_t [dsp_pkg::ndac-1:0] dac_hist[$];
	int acq_rearms[$];
	int dac_rearms[$];
	int acq_base;
	int dac_base;
	bit acq_armed;
	bit dac_armed;
	logic [dsp_pkg::nproc-1:0] pend_we;
	dsp_pkg::accbuf_addr_t [dsp_pkg::nproc-1:0] pend_addr;
	dsp_pkg::acc_result_t [dsp_pkg::nproc-1:0] pend_data;
	dsp_pkg::accbuf_addr_t [dsp_pkg::nproc-1:0] acc_cnt;
	int low_periods;
	bit after_done;
	bit prev_low;
	bit prev_done;

	assign errors = mismatches + failures;

	task automatic check_val(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name,
				expected, actual);
		end
	endtask

	task print_counts();
		$display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
	endtask

	task automatic clear_model();
		cycle = 0;
		adc_hist.delete();
		dac_hist.delete();
		acq_rearms.delete();
		dac_rearms.delete();
		acq_armed = 1'b0;
		dac_armed = 1'b0;
		acq_base = 0;
		dac_base = 0;
		pend_we = '0;
		acc_cnt = '0;
		low_periods = 0;
		after_done = 1'b1; // idle counts as after a run.
		prev_low = 1'b0;
		prev_done = 1'b0;
	endtask

	task automatic check_reset_values();
		check_val("proc_reset", {dsp_pkg::nproc{1'b1}}, proc_reset);
		check_val("last_shot_done", 0, last_shot_done);
		check_val("shot_cnt", 0, shot_cnt);
		for (int i = 0; i < dsp_pkg::nadc; i++) begin
			check_val($sformatf("acq_wr[%0d].we", i), 0, acq_wr[i].we);
		end
		for (int i = 0; i < dsp_pkg::ndac; i++) begin
			check_val($sformatf("dacmon_wr[%0d].we", i), 0, dacmon_wr[i].we);
		end
		for (int i = 0; i < dsp_pkg::nproc; i++) begin
			check_val($sformatf("accbuf_wr[%0d].we", i), 0, accbuf_wr[i].we);
		end
	endtask

	task automatic check_sequencer();
		bit low;
		low = (proc_reset == '0);
		checks++;
		if (proc_reset !== '0 && proc_reset !== '1) begin
			failures++;
			$display("ERROR at %0t: proc_reset is neither all low nor all high", $time);
		end
		if (low && !prev_low) begin
			low_periods++;
			after_done = 1'b0;
		end
		if (low) begin
			check_val("shot_cnt", low_periods - 1, shot_cnt);
		end
		if (after_done) begin
			check_val("shot_cnt", 0, shot_cnt);
		end
		if (last_shot_done === 1'b1) begin
			if (prev_done) begin
				failures++;
				$display("ERROR at %0t: last_shot_done stayed high for more than one cycle",
					$time);
			end
			check_val("shot_cnt", 0, shot_cnt);
			check_val("proc_reset low periods", exp_shots, low_periods);
			low_periods = 0;
			after_done = 1'b1;
		end
		prev_low = low;
		prev_done = (last_shot_done === 1'b1);
	endtask

	task automatic check_capture();
		dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] adc_old;
		dsp_pkg::dac_word_t [dsp_pkg::ndac-1:0] dac_old;
		int k;
		bit exp_we;
		adc_old = '0;
		dac_old = '0;
		adc_hist.push_back(adc);
		dac_hist.push_back(dac_word);
		if (rearm_capture === 1'b1) begin
			acq_rearms.push_back(cycle);
			dac_rearms.push_back(cycle);
		end
		while (acq_rearms.size() > 0 && acq_rearms[0] <= cycle - 4) begin
			acq_base = acq_rearms.pop_front();
			acq_armed = 1'b1;
		end
		while (dac_rearms.size() > 0 && dac_rearms[0] <= cycle - 3) begin
			dac_base = dac_rearms.pop_front();
			dac_armed = 1'b1;
		end
		if (adc_hist.size() > 4) begin
			adc_old = adc_hist.pop_front(); // word from four cycles back.
		end
		if (dac_hist.size() > 2) begin
			dac_old = dac_hist.pop_front();
		end
		k = cycle - 4 - acq_base;
		exp_we = acq_armed && k >= 0 && k <= (1 << dsp_pkg::acq_addr_w) - 2;
		for (int i = 0; i < dsp_pkg::nadc; i++) begin
			check_val($sformatf("acq_wr[%0d].we", i), exp_we, acq_wr[i].we);
			if (exp_we) begin
				check_val($sformatf("acq_wr[%0d].addr", i), k, acq_wr[i].addr);
				check_val($sformatf("acq_wr[%0d].data", i), adc_old[i], acq_wr[i].data);
			end
		end
		k = cycle - 3 - dac_base;
		exp_we = dac_armed && k >= 0 && k <= (1 << dsp_pkg::dacmon_addr_w) - 2;
		for (int i = 0; i < dsp_pkg::ndac; i++) begin
			check_val($sformatf("dacmon_wr[%0d].we", i), exp_we, dacmon_wr[i].we);
			if (exp_we) begin
				check_val($sformatf("dacmon_wr[%0d].addr", i), k, dacmon_wr[i].addr);
				check_val($sformatf("dacmon_wr[%0d].data", i), dac_old[i], dacmon_wr[i].data);
			end
		end
	endtask

	task automatic check_acc();
		for (int i = 0; i < dsp_pkg::nproc; i++) begin
			check_val($sformatf("accbuf_wr[%0d].we", i), pend_we[i], accbuf_wr[i].we);
			if (pend_we[i]) begin
				check_val($sformatf("accbuf_wr[%0d].addr", i), pend_addr[i], accbuf_wr[i].addr);
				check_val($sformatf("accbuf_wr[%0d].data", i), pend_data[i], accbuf_wr[i].data);
			end
			pend_we[i] = acc_valid[i];
			pend_addr[i] = acc_cnt[i];
			pend_data[i] = acc_result[i];
			if (reset_acc) begin
				acc_cnt[i] = '0;
			end else if (acc_valid[i] && acc_cnt[i] != '1) begin
				acc_cnt[i] = acc_cnt[i] + 1'b1; // stops at the last slot.
			end
		end
	endtask

	always @(posedge dspif) begin
		if (reset_applied) begin
			check_reset_values();
		end
		if (!rst_n) begin
			clear_model();
		end else begin
			check_sequencer();
			check_capture();
			check_acc();
			cycle++;
		end
		reset_applied = !rst_n;
	end

endmodule

// ==== test/tb_dsp.sv ====
/*
 * Testbench top that applies a table of shot, capture and accumulation rows to dsp_top.
 * Inputs change 1 ns after the rising edge; dsp_checker does the comparing.
 * A small core model answers proc_reset with proc_done and no_busy.
 */
`timescale 1ns/1ps

module tb_dsp;

	typedef enum logic [1:0] {op_shot, op_capture, op_acc} op_t;

	// capture rows use nstrobe as the capture length in cycles.
	typedef struct packed {
		op_t op;
		dsp_pkg::shot_cnt_t nshot;
		logic [15:0] core_delay;
		logic [15:0] nstrobe;
		logic [7:0] exp_shots;
	} row_t;

	logic dspif;
	logic rst_n;
	logic stb_start;
	dsp_pkg::shot_cnt_t nshot;
	logic [dsp_pkg::nproc-1:0] proc_done = '0;
	logic [dsp_pkg::nproc-1:0] no_busy = '0;
	logic rearm_capture;
	dsp_pkg::adc_word_t [dsp_pkg::nadc-1:0] adc;
	dsp_pkg::dac_word_t [dsp_pkg::ndac-1:0] dac_word;
	logic reset_acc;
	logic [dsp_pkg::nproc-1:0] acc_valid;
	dsp_pkg::acc_result_t [dsp_pkg::nproc-1:0] acc_result;
	logic [dsp_pkg::nproc-1:0] proc_reset;
	dsp_pkg::shot_cnt_t shot_cnt;
	logic last_shot_done;
	dsp_pkg::acq_wr_t [dsp_pkg::nadc-1:0] acq_wr;
	dsp_pkg::dacmon_wr_t [dsp_pkg::ndac-1:0] dacmon_wr;
	dsp_pkg::accbuf_wr_t [dsp_pkg::nproc-1:0] accbuf_wr;

	row_t rows[$];
	int seed = 32'h9a93_38a7;
	int core_delay = 0;
	int core_wait = 0;
	int exp_shots = 0;
	int cycles = 0;
	int limit = 20000;
	int errors;

	tb_clock clock_gen (.dspif(dspif), .rst_n(rst_n));

	dsp_top dut (
		.dspif(dspif), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
		.proc_done(proc_done), .no_busy(no_busy), .rearm_capture(rearm_capture),
		.adc(adc), .dac_word(dac_word), .reset_acc(reset_acc), .acc_valid(acc_valid),
		.acc_result(acc_result), .proc_reset(proc_reset), .shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done), .acq_wr(acq_wr), .dacmon_wr(dacmon_wr),
		.accbuf_wr(accbuf_wr)
	);

	dsp_checker chk (
		.dspif(dspif), .rst_n(rst_n), .rearm_capture(rearm_capture), .adc(adc),
		.dac_word(dac_word), .reset_acc(reset_acc), .acc_valid(acc_valid),
		.acc_result(acc_result), .proc_reset(proc_reset), .shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done), .acq_wr(acq_wr), .dacmon_wr(dacmon_wr),
		.accbuf_wr(accbuf_wr), .exp_shots(exp_shots), .errors(errors)
	);

	// core model answers each falling edge of proc_reset.
	always @(posedge dspif) begin
		if (!rst_n || proc_reset !== '0) begin
			core_wait <= 0;
			proc_done <= #1 '0;
			no_busy <= #1 '0;
		end else if (core_wait >= core_delay) begin
			proc_done <= #1 '1;
			no_busy <= #1 '1;
		end else begin
			core_wait <= core_wait + 1;
		end
	end

	always @(posedge dspif) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			chk.print_counts();
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic add_row(input op_t op, input int n, input int delay, input int strobes,
		input int shots);
		row_t r;
		r.op = op;
		r.nshot = n;
		r.core_delay = delay;
		r.nstrobe = strobes;
		r.exp_shots = shots;
		rows.push_back(r);
	endtask

	function automatic int row_length(input row_t r);
		int shots;
		shots = (r.nshot > 1) ? r.nshot : 1;
		if (r.op == op_shot) begin
			return shots * (r.core_delay + 8) + 8;
		end
		return r.nstrobe + 8;
	endfunction

	task automatic drive_data();
		for (int i = 0; i < dsp_pkg::nadc; i++) begin
			adc[i] = {$random(seed), $random(seed)};
		end
		for (int i = 0; i < dsp_pkg::ndac; i++) begin
			for (int j = 0; j < 8; j++) begin
				dac_word[i][32*j +: 32] = $random(seed);
			end
		end
		for (int i = 0; i < dsp_pkg::nproc; i++) begin
			acc_result[i] = {$random(seed), $random(seed)};
		end
	endtask

	task automatic next_cycle();
		@(posedge dspif);
		#1;
		drive_data();
	endtask

	task automatic run_row(input row_t r);
		int rnd;
		case (r.op)
			op_shot: begin
				nshot = r.nshot;
				core_delay = r.core_delay;
				exp_shots = r.exp_shots;
				next_cycle();
				stb_start = 1'b1;
				next_cycle();
				stb_start = 1'b0;
				do begin
					next_cycle();
				end while (last_shot_done !== 1'b1);
				repeat (3) next_cycle();
			end
			op_capture: begin
				rearm_capture = 1'b1;
				next_cycle();
				rearm_capture = 1'b0;
				repeat (r.nstrobe) next_cycle();
			end
			default: begin
				reset_acc = 1'b1;
				repeat (3) next_cycle();
				reset_acc = 1'b0;
				repeat (r.nstrobe) begin
					rnd = $random(seed);
					acc_valid = rnd[dsp_pkg::nproc-1:0];
					acc_valid[0] = 1'b1; // processor 0 gets every strobe.
					next_cycle();
				end
				acc_valid = '0;
				repeat (3) next_cycle();
			end
		endcase
	endtask

	initial begin
		stb_start = 1'b0;
		nshot = '0;
		rearm_capture = 1'b0;
		reset_acc = 1'b0;
		acc_valid = '0;
		adc = '0;
		dac_word = '0;
		acc_result = '0;
		add_row(op_shot, 0, 3, 0, 1);
		add_row(op_shot, 1, 0, 0, 1);
		add_row(op_shot, 5, 7, 0, 5);
		add_row(op_capture, 0, 0, 8220, 0);
		add_row(op_capture, 0, 0, 300, 0);
		add_row(op_capture, 0, 0, 600, 0); // rearm while acq still filling.
		add_row(op_acc, 0, 0, 2100, 0);
		add_row(op_acc, 0, 0, 40, 0);
		add_row(op_shot, 2, 1, 0, 2);
		for (int r = 0; r < rows.size(); r++) begin
			limit += 2 * row_length(rows[r]);
		end
		@(posedge rst_n);
		next_cycle();
		for (int r = 0; r < rows.size(); r++) begin
			run_row(rows[r]);
		end
		repeat (10) next_cycle();
		chk.print_counts();
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
common/dsp_pkg.sv
sequencer/shot_sequencer.sv
logic/acq_capture.sv
logic/dacmon_capture.sv
logic/acc_pointer.sv
logic/dsp_top.sv
test/tb_clock.sv
test/dsp_checker.sv
test/tb_dsp.sv

// ==== Bender.yml ====
package:
  name: dsp_core

sources:
  - common/dsp_pkg.sv
  - sequencer/shot_sequencer.sv
  - logic/acq_capture.sv
  - logic/dacmon_capture.sv
  - logic/acc_pointer.sv
  - logic/dsp_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/dsp_checker.sv
      - test/tb_dsp.sv
